//--- hdl/md_host_pkg.sv
//////////////////////////////
// Host download kinds, bus sizes
// and the cheat code word layout
//////////////////////////////
package md_host_pkg;

	// Bus and port sizes
	parameter int DL_INDEX_W = 8;
	parameter int DATA_W     = 16;
	parameter int LBA_W      = 32;

	// Download kinds, cartridges match on index bits 4:0
	parameter logic [DL_INDEX_W-1:0] IDX_MD    = 8'h01;
	parameter logic [DL_INDEX_W-1:0] IDX_SMS   = 8'h02;
	parameter logic [DL_INDEX_W-1:0] IDX_CHEAT = 8'hFF;

	//////////////////////////////
	// Cheat code layout
	//////////////////////////////

	parameter int CHEAT_W     = 128;
	parameter int CHEAT_WORDS = 8;

	// Field positions inside the assembled code
	parameter int CF_FLAGS_LSB = 96;
	parameter int CF_ADDR_LSB  = 64;
	parameter int CF_CMP_LSB   = 32;
	parameter int CF_REPL_LSB  = 0;

	// Byte offsets of the low and high word of each field
	parameter logic [3:0] OFS_FLAGS_LO = 4'd0;
	parameter logic [3:0] OFS_FLAGS_HI = 4'd2;
	parameter logic [3:0] OFS_ADDR_LO  = 4'd4;
	parameter logic [3:0] OFS_ADDR_HI  = 4'd6;
	parameter logic [3:0] OFS_CMP_LO   = 4'd8;
	parameter logic [3:0] OFS_CMP_HI   = 4'd10;
	parameter logic [3:0] OFS_REPL_LO  = 4'd12;
	parameter logic [3:0] OFS_REPL_HI  = 4'd14;

endpackage

//--- hdl/md_cart_pkg.sv
//////////////////////////////
// Cartridge header addresses, region
// and priority codes, header byte view
//////////////////////////////
package md_cart_pkg;

	// Header byte addresses
	parameter int unsigned HDR_REGION_A = 'h1F0;
	parameter int unsigned HDR_REGION_B = 'h1F2;
	parameter int unsigned HDR_END      = 'h200;

	// Console regions
	parameter logic [1:0] REGION_JP = 2'd0;
	parameter logic [1:0] REGION_US = 2'd1;
	parameter logic [1:0] REGION_EU = 2'd2;

	// Region priority orders for header mode
	parameter logic [1:0] PRIO_US_EU_JP = 2'd0;
	parameter logic [1:0] PRIO_EU_US_JP = 2'd1;
	parameter logic [1:0] PRIO_US_JP_EU = 2'd2;
	parameter logic [1:0] PRIO_JP_US_EU = 2'd3;

	// Auto region modes
	parameter logic [1:0] AUTO_HEADER   = 2'd0;
	parameter logic [1:0] AUTO_FILE_EXT = 2'd1;
	parameter logic [1:0] AUTO_OFF      = 2'd2;

	// Bits of the region nibble
	parameter int RGN_BIT_EU = 3;
	parameter int RGN_BIT_US = 2;
	parameter int RGN_BIT_JP = 0;

	// Header byte, either a character or a nibble pair
	// nib[1] is the high nibble, nib[0] the region field
	typedef union packed {
		logic [7:0]      ch;
		logic [1:0][3:0] nib;
	} hdr_char_u;

endpackage

//--- hdl/md_load_ctrl.sv
//////////////////////////////
// Wishbone download slave, download
// kind decode and start/end events
//////////////////////////////
`timescale 1ns/1ps

module md_load_ctrl import md_host_pkg::*; #(
	parameter int ADDR_W = 25
) (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [ADDR_W-1:0]     wb_adr_i,
	input  logic [DATA_W-1:0]     wb_dat_i,
	input  logic                  dl_active_i,
	input  logic [DL_INDEX_W-1:0] dl_index_i,
	output logic                  wb_ack_o,
	output logic                  cart_wr_o,
	output logic                  cheat_wr_o,
	output logic [ADDR_W-1:0]     wr_addr_o,
	output logic [DATA_W-1:0]     wr_data_o,
	output logic                  cart_start_o,
	output logic                  cart_end_o,
	output logic                  cheat_start_o,
	output logic                  cart_ms_o
);

	logic req;
	logic cart_kind;
	logic cheat_kind;
	logic cart_dl;
	logic cheat_dl;
	logic cart_dl_q;
	logic cheat_dl_q;

	// New bus cycle, ack follows one clock later
	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	assign cart_kind = (dl_index_i[4:0] == IDX_MD[4:0]) | (dl_index_i[4:0] == IDX_SMS[4:0]);
	assign cheat_kind = (dl_index_i == IDX_CHEAT);
	assign cart_dl = dl_active_i & cart_kind;
	assign cheat_dl = dl_active_i & cheat_kind;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			wb_ack_o <= 1'b0;
			cart_wr_o <= 1'b0;
			cheat_wr_o <= 1'b0;
			cart_dl_q <= 1'b0;
			cheat_dl_q <= 1'b0;
			cart_start_o <= 1'b0;
			cart_end_o <= 1'b0;
			cheat_start_o <= 1'b0;
			cart_ms_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
			// Write strobe goes only to the owner of the download
			cart_wr_o <= req & wb_we_i & cart_dl;
			cheat_wr_o <= req & wb_we_i & cheat_dl;

			cart_dl_q <= cart_dl;
			cheat_dl_q <= cheat_dl;
			cart_start_o <= cart_dl & ~cart_dl_q;
			cart_end_o <= ~cart_dl & cart_dl_q;
			cheat_start_o <= cheat_dl & ~cheat_dl_q;

			if (cart_dl & ~cart_dl_q)
				cart_ms_o <= (dl_index_i[4:0] == IDX_SMS[4:0]);
		end
	end

	// Address and data line up with the write strobe
	always_ff @(posedge clk_sys) begin
		if (req) begin
			wr_addr_o <= wb_adr_i;
			wr_data_o <= wb_dat_i;
		end
	end

endmodule

//--- hdl/md_header_scan.sv
//////////////////////////////
// Region flags from the cartridge header
//////////////////////////////
`timescale 1ns/1ps

module md_header_scan import md_host_pkg::*, md_cart_pkg::*; #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              sys_reset,
	input  logic              cart_wr_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  logic [DATA_W-1:0] wr_data_i,
	input  logic              cart_start_i,
	input  logic              cart_end_i,
	output logic              hdr_j_o,
	output logic              hdr_u_o,
	output logic              hdr_e_o,
	output logic              hdr_ready_o
);

	hdr_char_u  lo_c;
	hdr_char_u  hi_c;
	logic [3:0] rgn_hex;
	logic [2:0] flag_q;
	logic [2:0] flag_nxt;

	// Letter to {e,u,j}
	function automatic logic [2:0] letter_flags(input hdr_char_u c);
		logic [2:0] f;
		case (c.ch)
			"J":     f = 3'b001;
			"U":     f = 3'b010;
			"E":     f = 3'b100;
			default: f = 3'b000;
		endcase
		return f;
	endfunction

	function automatic logic [2:0] nib_flags(input logic [3:0] n);
		return {n[RGN_BIT_EU], n[RGN_BIT_US], n[RGN_BIT_JP]};
	endfunction

	assign lo_c = wr_data_i[7:0];
	assign hi_c = wr_data_i[15:8];
	// Hex letters A-F land on 10-15
	assign rgn_hex = lo_c.nib[0] - 4'd7;

	always_comb begin
		flag_nxt = flag_q;
		if (cart_start_i)
			flag_nxt = 3'b000;
		if (cart_wr_i && wr_addr_i == ADDR_W'(HDR_REGION_A)) begin
			if (letter_flags(lo_c) != 3'b000)
				flag_nxt = flag_nxt | letter_flags(lo_c);
			else if (lo_c.ch >= "0" && lo_c.ch <= "9")
				flag_nxt = nib_flags(lo_c.nib[0]);
			else if (lo_c.ch >= "A" && lo_c.ch <= "F")
				flag_nxt = nib_flags(rgn_hex);
			// Second letter in the high byte
			flag_nxt = flag_nxt | letter_flags(hi_c);
		end
		if (cart_wr_i && wr_addr_i == ADDR_W'(HDR_REGION_B))
			flag_nxt = flag_nxt | letter_flags(lo_c);
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			flag_q <= 3'b000;
			hdr_ready_o <= 1'b0;
		end else begin
			flag_q <= flag_nxt;
			if (cart_wr_i && wr_addr_i == ADDR_W'(HDR_END))
				hdr_ready_o <= 1'b1;
			else if (cart_end_i)
				hdr_ready_o <= 1'b0;
		end
	end

	assign hdr_j_o = flag_q[0];
	assign hdr_u_o = flag_q[1];
	assign hdr_e_o = flag_q[2];

endmodule

//--- hdl/md_region_select.sv
//////////////////////////////
// Console region choice on header ready
//////////////////////////////
`timescale 1ns/1ps

module md_region_select import md_host_pkg::*, md_cart_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  hdr_ready_i,
	input  logic                  hdr_j_i,
	input  logic                  hdr_u_i,
	input  logic                  hdr_e_i,
	input  logic                  cart_ms_i,
	input  logic [1:0]            auto_mode_i,
	input  logic [1:0]            prio_mode_i,
	input  logic [DL_INDEX_W-1:0] dl_index_i,
	output logic [1:0]            region_o,
	output logic                  region_set_o
);

	logic ready_q;
	logic ready_rise;
	logic ready_fall;

	// First present region in the priority order, else the order's head
	function automatic logic [1:0] pick_region(input logic [1:0] prio,
			input logic j, input logic u, input logic e);
		logic [1:0] r;
		r = REGION_US;
		case (prio)
			PRIO_US_EU_JP: r = u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			PRIO_EU_US_JP: r = e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			PRIO_US_JP_EU: r = u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			PRIO_JP_US_EU: r = j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	assign ready_rise = hdr_ready_i & ~ready_q;
	assign ready_fall = ~hdr_ready_i & ready_q;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			ready_q <= 1'b0;
			region_o <= REGION_JP;
			region_set_o <= 1'b0;
		end else begin
			ready_q <= hdr_ready_i;
			if (ready_rise && !cart_ms_i) begin
				case (auto_mode_i)
					AUTO_HEADER: begin
						region_o <= pick_region(prio_mode_i, hdr_j_i, hdr_u_i, hdr_e_i);
						region_set_o <= 1'b1;
					end
					AUTO_FILE_EXT: begin
						region_o <= dl_index_i[DL_INDEX_W-1 -: 2];
						region_set_o <= |dl_index_i;
					end
					// AUTO_OFF and the spare code leave the region alone
					default: ;
				endcase
			end
			if (ready_fall)
				region_set_o <= 1'b0;
		end
	end

endmodule

//--- hdl/md_cheat_loader.sv
//////////////////////////////
// Cheat code assembly from bus words
//////////////////////////////
`timescale 1ns/1ps

module md_cheat_loader import md_host_pkg::*; #(
	parameter int ADDR_W = 25
) (
	input  logic               clk_sys,
	input  logic               sys_reset,
	input  logic               cheat_wr_i,
	input  logic [ADDR_W-1:0]  wr_addr_i,
	input  logic [DATA_W-1:0]  wr_data_i,
	input  logic               cheat_start_i,
	input  logic               cart_start_i,
	output logic [CHEAT_W-1:0] code_o,
	output logic               code_valid_o,
	output logic               code_clear_o
);

	// Any new download drops the codes already loaded
	assign code_clear_o = cheat_start_i | cart_start_i;

	always_ff @(posedge clk_sys) begin
		if (code_clear_o) begin
			code_o <= '0;
		end else if (cheat_wr_i) begin
			case (wr_addr_i[3:0])
				OFS_FLAGS_LO: code_o[CF_FLAGS_LSB +: DATA_W] <= wr_data_i;
				OFS_FLAGS_HI: code_o[CF_FLAGS_LSB + DATA_W +: DATA_W] <= wr_data_i;
				OFS_ADDR_LO:  code_o[CF_ADDR_LSB +: DATA_W] <= wr_data_i;
				OFS_ADDR_HI:  code_o[CF_ADDR_LSB + DATA_W +: DATA_W] <= wr_data_i;
				OFS_CMP_LO:   code_o[CF_CMP_LSB +: DATA_W] <= wr_data_i;
				OFS_CMP_HI:   code_o[CF_CMP_LSB + DATA_W +: DATA_W] <= wr_data_i;
				OFS_REPL_LO:  code_o[CF_REPL_LSB +: DATA_W] <= wr_data_i;
				OFS_REPL_HI:  code_o[CF_REPL_LSB + DATA_W +: DATA_W] <= wr_data_i;
				default: ;
			endcase
		end
	end

	// Last word of a code clocks it in
	always_ff @(posedge clk_sys) begin
		if (sys_reset)
			code_valid_o <= 1'b0;
		else
			code_valid_o <= cheat_wr_i && (wr_addr_i[3:0] == OFS_REPL_HI);
	end

endmodule

//--- hdl/md_backup_seq.sv
//////////////////////////////
// Backup RAM load/save sector sequencer
//////////////////////////////
`timescale 1ns/1ps

module md_backup_seq import md_host_pkg::*; #(
	parameter int SECTORS = 128
) (
	input  logic             clk_sys,
	input  logic             sys_reset,
	input  logic             cart_start_i,
	input  logic             cart_end_i,
	input  logic             img_mounted_i,
	input  logic             img_readonly_i,
	input  logic             img_size_nz_i,
	input  logic             bk_load_i,
	input  logic             bk_save_i,
	input  logic             sd_ack_i,
	output logic [LBA_W-1:0] sd_lba_o,
	output logic             sd_rd_o,
	output logic             sd_wr_o,
	output logic             busy_o
);

	logic dl_q;
	logic bk_ena;
	logic loading;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic load_rise;
	logic save_rise;
	logic ack_rise;
	logic ack_fall;
	logic last_sector;

	assign load_rise = bk_load_i & ~old_load;
	assign save_rise = bk_save_i & ~old_save;
	assign ack_rise = sd_ack_i & ~old_ack;
	assign ack_fall = ~sd_ack_i & old_ack;
	assign last_sector = (sd_lba_o == LBA_W'(SECTORS - 1));

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			dl_q <= 1'b0;
			bk_ena <= 1'b0;
			loading <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack <= 1'b0;
			sd_lba_o <= '0;
			sd_rd_o <= 1'b0;
			sd_wr_o <= 1'b0;
			busy_o <= 1'b0;
		end else begin
			old_load <= bk_load_i;
			old_save <= bk_save_i;
			old_ack <= sd_ack_i;

			//////////////////////////////
			// Download window and enable
			//////////////////////////////
			if (cart_start_i)
				dl_q <= 1'b1;
			else if (cart_end_i)
				dl_q <= 1'b0;

			// Save image is mounted while the cartridge loads
			if (cart_start_i)
				bk_ena <= 1'b0;
			else if (dl_q && img_mounted_i && !img_readonly_i)
				bk_ena <= 1'b1;

			// Request drops once the host takes it
			if (ack_rise) begin
				sd_rd_o <= 1'b0;
				sd_wr_o <= 1'b0;
			end

			//////////////////////////////
			// Sweep control
			//////////////////////////////
			if (!busy_o) begin
				if (bk_ena && (load_rise || save_rise)) begin
					busy_o <= 1'b1;
					loading <= bk_load_i;
					sd_lba_o <= '0;
					sd_rd_o <= bk_load_i;
					sd_wr_o <= ~bk_load_i;
				end
				// Automatic restore after the cartridge is in
				if (cart_end_i && img_size_nz_i && bk_ena) begin
					busy_o <= 1'b1;
					loading <= 1'b1;
					sd_lba_o <= '0;
					sd_rd_o <= 1'b1;
					sd_wr_o <= 1'b0;
				end
			end else if (ack_fall) begin
				if (last_sector) begin
					busy_o <= 1'b0;
					loading <= 1'b0;
				end else begin
					sd_lba_o <= sd_lba_o + 1'b1;
					sd_rd_o <= loading;
					sd_wr_o <= ~loading;
				end
			end
		end
	end

endmodule

//--- hdl/md_loader_top.sv
//////////////////////////////
// Host loading top level
//////////////////////////////
`timescale 1ns/1ps

module md_loader_top import md_host_pkg::*; #(
	parameter int ADDR_W  = 25,
	parameter int SECTORS = 128
) (
	input  logic                  clk_sys,
	input  logic                  sys_reset,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [ADDR_W-1:0]     wb_adr_i,
	input  logic [DATA_W-1:0]     wb_dat_i,
	output logic                  wb_ack_o,
	input  logic                  dl_active_i,
	input  logic [DL_INDEX_W-1:0] dl_index_i,
	input  logic [1:0]            auto_mode_i,
	input  logic [1:0]            prio_mode_i,
	input  logic                  img_mounted_i,
	input  logic                  img_readonly_i,
	input  logic                  img_size_nz_i,
	input  logic                  bk_load_i,
	input  logic                  bk_save_i,
	input  logic                  sd_ack_i,
	output logic [1:0]            region_o,
	output logic                  region_set_o,
	output logic [CHEAT_W-1:0]    code_o,
	output logic                  code_valid_o,
	output logic                  code_clear_o,
	output logic [LBA_W-1:0]      sd_lba_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	output logic                  busy_o
);

	logic              cart_wr;
	logic              cheat_wr;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic              cart_start;
	logic              cart_end;
	logic              cheat_start;
	logic              cart_ms;
	logic              hdr_j;
	logic              hdr_u;
	logic              hdr_e;
	logic              hdr_ready;

	md_load_ctrl #(.ADDR_W(ADDR_W)) u_load_ctrl (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i),
		.wb_ack_o(wb_ack_o), .cart_wr_o(cart_wr), .cheat_wr_o(cheat_wr),
		.wr_addr_o(wr_addr), .wr_data_o(wr_data),
		.cart_start_o(cart_start), .cart_end_o(cart_end),
		.cheat_start_o(cheat_start), .cart_ms_o(cart_ms)
	);

	md_header_scan #(.ADDR_W(ADDR_W)) u_header_scan (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.cart_wr_i(cart_wr), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.cart_start_i(cart_start), .cart_end_i(cart_end),
		.hdr_j_o(hdr_j), .hdr_u_o(hdr_u), .hdr_e_o(hdr_e), .hdr_ready_o(hdr_ready)
	);

	md_region_select u_region_select (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.hdr_ready_i(hdr_ready), .hdr_j_i(hdr_j), .hdr_u_i(hdr_u), .hdr_e_i(hdr_e),
		.cart_ms_i(cart_ms), .auto_mode_i(auto_mode_i), .prio_mode_i(prio_mode_i),
		.dl_index_i(dl_index_i),
		.region_o(region_o), .region_set_o(region_set_o)
	);

	md_cheat_loader #(.ADDR_W(ADDR_W)) u_cheat_loader (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.cheat_wr_i(cheat_wr), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.cheat_start_i(cheat_start), .cart_start_i(cart_start),
		.code_o(code_o), .code_valid_o(code_valid_o), .code_clear_o(code_clear_o)
	);

	md_backup_seq #(.SECTORS(SECTORS)) u_backup_seq (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.cart_start_i(cart_start), .cart_end_i(cart_end),
		.img_mounted_i(img_mounted_i), .img_readonly_i(img_readonly_i),
		.img_size_nz_i(img_size_nz_i),
		.bk_load_i(bk_load_i), .bk_save_i(bk_save_i), .sd_ack_i(sd_ack_i),
		.sd_lba_o(sd_lba_o), .sd_rd_o(sd_rd_o), .sd_wr_o(sd_wr_o), .busy_o(busy_o)
	);

endmodule

//--- bench/md_loader_props.sv
//////////////////////////////
// Bound checks for the host loader
//////////////////////////////
`timescale 1ns/1ps

module md_loader_props import md_host_pkg::*, md_cart_pkg::*; #(
	parameter int ADDR_W  = 25,
	parameter int SECTORS = 128
) (
	input logic                  clk_sys,
	input logic                  sys_reset,
	input logic                  wb_cyc_i,
	input logic                  wb_stb_i,
	input logic                  wb_we_i,
	input logic [ADDR_W-1:0]     wb_adr_i,
	input logic [DATA_W-1:0]     wb_dat_i,
	input logic                  wb_ack_o,
	input logic                  dl_active_i,
	input logic [DL_INDEX_W-1:0] dl_index_i,
	input logic [1:0]            auto_mode_i,
	input logic [1:0]            prio_mode_i,
	input logic                  bk_load_i,
	input logic                  bk_save_i,
	input logic                  sd_ack_i,
	input logic [1:0]            region_o,
	input logic                  region_set_o,
	input logic [CHEAT_W-1:0]    code_o,
	input logic                  code_valid_o,
	input logic                  code_clear_o,
	input logic [LBA_W-1:0]      sd_lba_o,
	input logic                  sd_rd_o,
	input logic                  sd_wr_o,
	input logic                  busy_o
);

	int err_cnt = 0;
	int exp_lba;
	logic rst_q;
	logic dl_q;
	logic ms_q;
	logic ack_q;
	logic load_q;
	logic save_q;
	logic last_load;
	logic [2:0] flags_q;
	logic [1:0] exp_region_q;
	logic [CHEAT_W-1:0] cheat_sh;
	logic [6:0] cheat_base;
	logic wr_seen;
	logic cart_kind;
	logic dl_rise;
	logic end_ack;
	logic cheat_wr;
	logic cheat_last;

	// Flags {eu,us,jp} of the first region byte
	function automatic logic [2:0] byte_flags(input logic [7:0] b);
		logic [3:0] n;
		n = 4'h0;
		if (b == "J" || b == "U" || b == "E")
			return {b == "E", b == "U", b == "J"};
		if (b >= "0" && b <= "9")
			n = b[3:0];
		else if (b >= "A" && b <= "F")
			n = 4'(b - 8'd7);
		return {n[3], n[2], n[0]};
	endfunction

	// First present region in the priority order wins
	function automatic logic [1:0] prio_pick(input logic [1:0] prio, input logic [2:0] f);
		logic [5:0] order;
		logic [1:0] pick;
		case (prio)
			PRIO_US_EU_JP: order = {REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = {REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = {REGION_US, REGION_JP, REGION_EU};
			default:       order = {REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[5:4];
		for (int k = 0; k < 3; k++)
			if (f[order[k*2 +: 2]])
				pick = order[k*2 +: 2];
		return pick;
	endfunction

	assign wr_seen = wb_cyc_i & wb_stb_i & wb_ack_o & wb_we_i & dl_active_i;
	assign cart_kind = (dl_index_i[4:0] == IDX_MD[4:0]) | (dl_index_i[4:0] == IDX_SMS[4:0]);
	assign dl_rise = dl_active_i & ~dl_q;
	assign end_ack = wr_seen & cart_kind & (wb_adr_i == ADDR_W'(HDR_END));
	assign cheat_wr = wr_seen & (dl_index_i == IDX_CHEAT);
	assign cheat_last = cheat_wr & (wb_adr_i[3:0] == 4'd14);
	// Flags field is the top word of the code
	assign cheat_base = {2'd3 - wb_adr_i[3:2], wb_adr_i[1], 4'b0000};

	always_ff @(posedge clk_sys)
		rst_q <= sys_reset;

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			dl_q <= 1'b0;
			ms_q <= 1'b0;
			ack_q <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
			last_load <= 1'b0;
			flags_q <= 3'b000;
			exp_region_q <= REGION_JP;
			cheat_sh <= '0;
			exp_lba <= 0;
		end else begin
			dl_q <= dl_active_i;
			ack_q <= sd_ack_i;
			load_q <= bk_load_i;
			save_q <= bk_save_i;
			if (dl_rise) begin
				flags_q <= 3'b000;
				ms_q <= (dl_index_i[4:0] == IDX_SMS[4:0]);
				cheat_sh <= '0;
			end
			if (wr_seen && cart_kind && wb_adr_i == ADDR_W'(HDR_REGION_A))
				flags_q <= byte_flags(wb_dat_i[7:0]);
			if (end_ack)
				exp_region_q <= (auto_mode_i == AUTO_FILE_EXT) ? dl_index_i[7:6] :
					prio_pick(prio_mode_i, flags_q);
			if (cheat_wr)
				cheat_sh[cheat_base +: DATA_W] <= wb_dat_i;
			if (bk_load_i && !load_q)
				last_load <= 1'b1;
			else if (bk_save_i && !save_q)
				last_load <= 1'b0;
			// Sector count restarts with each sweep request or download end
			if ((bk_load_i && !load_q) || (bk_save_i && !save_q) || (dl_q && !dl_active_i))
				exp_lba <= 0;
			else if (!sd_ack_i && ack_q)
				exp_lba <= exp_lba + 1;
		end
	end

	//////////////////////////////
	// Bus and reset
	//////////////////////////////
	a_idle: assert property (@(posedge clk_sys) (rst_q && !sys_reset) |->
		!(wb_ack_o || region_set_o || code_valid_o || code_clear_o ||
		sd_rd_o || sd_wr_o || busy_o))
		else begin
			$error("Control output high right after reset");
			err_cnt++;
		end
	a_ack: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
		else begin
			$error("Bus strobe was not acknowledged one cycle later");
			err_cnt++;
		end
	a_ack_one: assert property (@(posedge clk_sys) disable iff (sys_reset) wb_ack_o |=> !wb_ack_o)
		else begin
			$error("Acknowledge held longer than one cycle");
			err_cnt++;
		end

	//////////////////////////////
	// Region and cheats
	//////////////////////////////
	a_region: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(end_ack && !ms_q && auto_mode_i != AUTO_OFF) |->
		##2 (region_set_o && region_o == exp_region_q))
		else begin
			$error("FAILED region_o got %h expected %h set %h", region_o, exp_region_q,
				region_set_o);
			err_cnt++;
		end
	a_sms: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(end_ack && ms_q) |-> ##2 !region_set_o)
		else begin
			$error("Region was set for an SMS cartridge");
			err_cnt++;
		end
	a_code: assert property (@(posedge clk_sys) disable iff (sys_reset)
		cheat_last |=> (code_valid_o && code_o == cheat_sh))
		else begin
			$error("FAILED code_o got %h expected %h", code_o, cheat_sh);
			err_cnt++;
		end
	a_clear: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(dl_rise && (cart_kind || dl_index_i == IDX_CHEAT)) |=> code_clear_o)
		else begin
			$error("No code clear at download start");
			err_cnt++;
		end

	//////////////////////////////
	// Backup sweeps
	//////////////////////////////
	a_start: assert property (@(posedge clk_sys) disable iff (sys_reset)
		((bk_load_i && !load_q || bk_save_i && !save_q) && !busy_o) |=> busy_o)
		else begin
			$error("Backup sweep did not start");
			err_cnt++;
		end
	a_lba: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(sd_rd_o || sd_wr_o) |-> sd_lba_o == LBA_W'(exp_lba))
		else begin
			$error("FAILED sd_lba_o got %h expected %h", sd_lba_o, exp_lba);
			err_cnt++;
		end
	a_dir: assert property (@(posedge clk_sys) disable iff (sys_reset)
		(!sd_rd_o || last_load) && (!sd_wr_o || !last_load))
		else begin
			$error("Sector request in the wrong direction");
			err_cnt++;
		end
	a_end: assert property (@(posedge clk_sys) disable iff (sys_reset)
		$fell(busy_o) |-> exp_lba == SECTORS)
		else begin
			$error("FAILED busy_o fell after %h sectors expected %h", exp_lba, SECTORS);
			err_cnt++;
		end

endmodule

bind md_loader_top md_loader_props #(.ADDR_W(ADDR_W), .SECTORS(SECTORS)) u_props (.*);

//--- bench/tb_md_loader.sv
//////////////////////////////
// Host loader testbench
//////////////////////////////
`timescale 1ns/1ps

module tb_md_loader;
	import md_host_pkg::*;
	import md_cart_pkg::*;

	localparam int ADDR_W    = 25;
	localparam int SECTORS   = 128;
	localparam int N_WRITES  = 200;
	localparam int CYC_BOUND = 24;
	localparam int WD_NS     = (N_WRITES + 2 * SECTORS) * CYC_BOUND * 8;

	logic clk_sys, sys_reset;
	logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [ADDR_W-1:0] wb_adr_i;
	logic [DATA_W-1:0] wb_dat_i;
	logic dl_active_i;
	logic [DL_INDEX_W-1:0] dl_index_i;
	logic [1:0] auto_mode_i, prio_mode_i, region_o;
	logic img_mounted_i, img_readonly_i, img_size_nz_i;
	logic bk_load_i, bk_save_i, sd_ack_i;
	logic region_set_o, code_valid_o, code_clear_o;
	logic [CHEAT_W-1:0] code_o;
	logic [LBA_W-1:0] sd_lba_o;
	logic sd_rd_o, sd_wr_o, busy_o;
	logic [31:0] lcg_state = 32'd20917;

	md_loader_top #(.ADDR_W(ADDR_W), .SECTORS(SECTORS)) dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// One clock, then the drive offset
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_cycle(input int adr, input logic [15:0] dat, input logic we);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = ADDR_W'(adr);
		wb_dat_i = dat;
		do tick(); while (!wb_ack_o);
		tick();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	// Header window with the region byte at 0x1F0
	task automatic load_cart(input logic [7:0] idx, input logic [7:0] rgn);
		logic [15:0] d;
		dl_index_i = idx;
		tick();
		dl_active_i = 1'b1;
		repeat (3) tick();
		for (int a = 'h1E0; a <= HDR_END; a += 2) begin
			if (a == HDR_REGION_A)
				d = {8'h20, rgn};
			else if (a == HDR_REGION_B)
				d = 16'h2020;
			else
				d = lcg_next();
			bus_cycle(a, d, 1'b1);
		end
		repeat (3) tick();
		dl_active_i = 1'b0;
		repeat (6) tick();
	endtask

	task automatic load_cheats(input int codes);
		dl_index_i = IDX_CHEAT;
		tick();
		dl_active_i = 1'b1;
		repeat (2) tick();
		for (int a = 0; a < codes * 16; a += 2)
			bus_cycle(a, lcg_next(), 1'b1);
		tick();
		dl_active_i = 1'b0;
		repeat (4) tick();
	endtask

	// Host side of the sector port with random latency
	task automatic run_sweep(input logic load);
		int gap;
		if (load)
			bk_load_i = 1'b1;
		else
			bk_save_i = 1'b1;
		tick();
		bk_load_i = 1'b0;
		bk_save_i = 1'b0;
		while (busy_o) begin
			if (sd_rd_o || sd_wr_o) begin
				gap = lcg_next() % 4;
				repeat (gap) tick();
				sd_ack_i = 1'b1;
				while (sd_rd_o || sd_wr_o)
					tick();
				repeat (gap + 1) tick();
				sd_ack_i = 1'b0;
			end
			tick();
		end
	endtask

	initial begin
		#(WD_NS);
		$display("TEST FAILED");
		$fatal(1, "Watchdog timeout, the run did not finish in time");
	end

	always @(posedge clk_sys) begin
		if (dut.u_props.err_cnt != 0) begin
			$display("TEST FAILED");
			$fatal(1, "Assertion failure in the loader checks");
		end
	end

	initial begin
		sys_reset = 1'b1;
		{wb_cyc_i, wb_stb_i, wb_we_i, dl_active_i} = '0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		dl_index_i = '0;
		auto_mode_i = AUTO_HEADER;
		prio_mode_i = PRIO_US_EU_JP;
		{img_mounted_i, img_readonly_i, img_size_nz_i} = '0;
		{bk_load_i, bk_save_i, sd_ack_i} = '0;
		repeat (16) @(posedge clk_sys);
		#1 sys_reset = 1'b0;
		repeat (2) tick();
		bus_cycle('h40, 16'h0000, 1'b0);

		// Header mode
		load_cart(IDX_MD, "U");
		prio_mode_i = PRIO_JP_US_EU;
		load_cart(IDX_MD, "J");
		prio_mode_i = PRIO_US_EU_JP;
		load_cart(IDX_MD, "8");
		prio_mode_i = PRIO_EU_US_JP;
		load_cart(IDX_MD, "C");
		load_cart(IDX_SMS, "U");

		// File extension mode
		auto_mode_i = AUTO_FILE_EXT;
		load_cart(8'h41, "E");
		load_cart(8'h81, "J");
		load_cart(8'h42, "U");

		load_cheats(2);

		// Writable save image mounted during a cartridge load
		auto_mode_i = AUTO_HEADER;
		img_mounted_i = 1'b1;
		load_cart(IDX_MD, "E");
		run_sweep(1'b1);
		repeat (4) tick();
		run_sweep(1'b0);

		repeat (4) tick();
		if (dut.u_props.err_cnt == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			$display("TEST FAILED");
			$fatal(1, "Checks failed during the run");
		end
	end

endmodule

//--- tb.f
hdl/md_host_pkg.sv
hdl/md_cart_pkg.sv
hdl/md_load_ctrl.sv
hdl/md_header_scan.sv
hdl/md_region_select.sv
hdl/md_cheat_loader.sv
hdl/md_backup_seq.sv
hdl/md_loader_top.sv
bench/md_loader_props.sv
bench/tb_md_loader.sv

//--- Bender.yml
package:
  name: md_loader

sources:
  - hdl/md_host_pkg.sv
  - hdl/md_cart_pkg.sv
  - hdl/md_load_ctrl.sv
  - hdl/md_header_scan.sv
  - hdl/md_region_select.sv
  - hdl/md_cheat_loader.sv
  - hdl/md_backup_seq.sv
  - hdl/md_loader_top.sv
  - target: test
    files:
      - bench/md_loader_props.sv
      - bench/tb_md_loader.sv
